// ==== bench/tb_ilk_tx.sv ====
// self-checking testbench for the two-channel transmit front end, compiled with the RTL from files.f
`timescale 1ns/1ns

module tb_ilk_tx;

	import ilk_tx_pkg::*;

	// expected beat is {data, word count, eop code, sop}
	localparam int beat_width = dat_width + log_dat_words + 5;
	localparam int out_width = dat_width + log_dat_words + chan_width + 6;
	localparam int total_beats = 300;
	localparam int cycle_limit = 4 * total_beats + 200;

	logic clk;
	logic arst;
	logic cfg_wr;
	logic [cfg_addr_width-1:0] cfg_addr;
	logic [chan_width-1:0] cfg_wdata;
	logic [chan_width-1:0] cfg_rdata;
	logic [dat_width-1:0] s_data [2];
	logic [empty_width-1:0] s_empty [2];
	logic [1:0] s_sop;
	logic [1:0] s_eop;
	logic [1:0] s_valid;
	logic [1:0] s_err;
	logic ch0_avl_ready;
	logic ch1_avl_ready;
	logic [log_dat_words-1:0] out_num_valid;
	logic [dat_width-1:0] out_data;
	logic [chan_width-1:0] out_chan;
	logic out_sop;
	logic [3:0] out_eopbits;
	logic out_ready;
	logic out_valid;

	// scoreboard and stimulus state
	logic [beat_width-1:0] exp_q0 [$];
	logic [beat_width-1:0] exp_q1 [$];
	logic [beat_width-1:0] head0;
	logic [beat_width-1:0] head1;
	logic [1:0] head_valid;
	int target [2];
	int issued [2];
	int accepted [2];
	int pkt_pos [2];
	int pkt_len [2];
	int errors;
	int beats_checked;
	int tests_run;
	int cycles;
	int run_len;
	logic last_ch;
	logic [31:0] lcg_state;
	logic gap_mode;
	logic bp_mode;
	logic fair_check;
	logic [1:0] dis_check;
	logic [chan_width-1:0] id_model [2];
	logic rd_check;
	logic [chan_width-1:0] rd_expect;
	logic prev_ready;
	logic prev_arst;
	logic [out_width-1:0] prev_out;

	wire [1:0] rdy = {ch1_avl_ready, ch0_avl_ready};
	wire take = out_valid && out_ready;
	wire take_is0 = out_chan == id_model[0];
	wire take_is1 = out_chan == id_model[1];
	wire mapped = take && (take_is0 || take_is1);
	wire [beat_width-1:0] exp_beat = take_is1 ? head1 : head0;
	wire exp_avail = take_is1 ? head_valid[1] : head_valid[0];
	wire [dat_width-1:0] exp_data = exp_beat[beat_width-1:7];
	wire [log_dat_words-1:0] exp_num = exp_beat[6:5];
	wire [3:0] exp_code = exp_beat[4:1];
	wire exp_sop = exp_beat[0];
	wire [out_width-1:0] out_all = {out_data, out_num_valid, out_chan, out_sop, out_eopbits,
		out_valid};

	ilk_tx_top dut (
		.clk(clk),
		.arst(arst),
		.cfg_wr(cfg_wr),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.cfg_rdata(cfg_rdata),
		.ch0_avl_data(s_data[0]),
		.ch0_avl_sop(s_sop[0]),
		.ch0_avl_eop(s_eop[0]),
		.ch0_avl_valid(s_valid[0]),
		.ch0_avl_empty(s_empty[0]),
		.ch0_avl_error(s_err[0]),
		.ch0_avl_ready(ch0_avl_ready),
		.ch1_avl_data(s_data[1]),
		.ch1_avl_sop(s_sop[1]),
		.ch1_avl_eop(s_eop[1]),
		.ch1_avl_valid(s_valid[1]),
		.ch1_avl_empty(s_empty[1]),
		.ch1_avl_error(s_err[1]),
		.ch1_avl_ready(ch1_avl_ready),
		.out_num_valid(out_num_valid),
		.out_data(out_data),
		.out_chan(out_chan),
		.out_sop(out_sop),
		.out_eopbits(out_eopbits),
		.out_ready(out_ready),
		.out_valid(out_valid)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	////////////////////////////////////////
	// helpers

	function automatic logic [15:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	// Interlaken view of one Avalon beat, straight from the word count and eop code rules
	function automatic logic [beat_width-1:0] expect_beat(input logic [dat_width-1:0] data,
		input logic sop, input logic eop, input logic [3:0] empty, input logic err);
		logic [log_dat_words-1:0] num;
		logic [3:0] code;
		logic [3:0] last_bytes;
		last_bytes = 4'd8 - {1'b0, empty[2:0]};
		num = eop ? 2'd2 - {1'b0, empty[3]} : 2'd2;
		if (!eop) begin
			code = eop_none;
		end else if (err) begin
			code = eop_error;
		end else begin
			code = eop_flag | {1'b0, last_bytes[2:0]};
		end
		return {data, num, code, sop};
	endfunction

	task automatic report_mismatch(input string name, input logic [143:0] expected,
		input logic [143:0] actual);
		$display("Mismatch at %0t ns: %s expected %0h actual %0h", $time, name, expected, actual);
		errors++;
	endtask

	task automatic report_fault(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		errors++;
	endtask

	task automatic cfg_write(input logic [cfg_addr_width-1:0] addr,
		input logic [chan_width-1:0] value);
		cfg_wr <= 1'b1;
		cfg_addr <= addr;
		cfg_wdata <= value;
		@(posedge clk);
		cfg_wr <= 1'b0;
		if (addr == cfg_addr_chan0) begin
			id_model[0] <= value;
		end else if (addr == cfg_addr_chan1) begin
			id_model[1] <= value;
		end
	endtask

	task automatic cfg_check(input logic [cfg_addr_width-1:0] addr,
		input logic [chan_width-1:0] value);
		cfg_addr <= addr;
		rd_expect <= value;
		rd_check <= 1'b1;
		@(posedge clk);
		rd_check <= 1'b0;
	endtask

	task automatic add_traffic(input int n0, input int n1);
		target[0] <= target[0] + n0;
		target[1] <= target[1] + n1;
		@(posedge clk);
	endtask

	// every beat sent has been taken and nothing is left on the output
	task automatic wait_drained();
		@(negedge clk);
		while (accepted[0] != target[0] || accepted[1] != target[1] || out_valid) begin
			@(negedge clk);
		end
		@(posedge clk);
	endtask

	task automatic test_done(input string name);
		tests_run++;
		$display("test %0d %s finished, errors so far %0d", tests_run, name, errors);
	endtask

	////////////////////////////////////////
	// sources and sink ready

	always @(posedge clk) begin
		logic [15:0] r;
		logic [dat_width-1:0] d;
		logic eop;
		if (!arst) begin
			r = lcg_next();
			out_ready <= !bp_mode || (r[3:0] < 4'd11);
			for (int c = 0; c < 2; c++) begin
				// a beat stays on the port until it is accepted
				if (!s_valid[c] || rdy[c]) begin
					r = lcg_next();
					if (issued[c] < target[c] && (!gap_mode || r[1:0] != 2'd0)) begin
						if (pkt_pos[c] == 0) begin
							r = lcg_next();
							pkt_len[c] = 1 + int'(r[1:0]);
						end
						for (int k = 0; k < 8; k++) begin
							r = lcg_next();
							d[16*k +: 16] = r;
						end
						eop = (pkt_pos[c] == pkt_len[c] - 1);
						r = lcg_next();
						s_data[c] <= d;
						s_sop[c] <= (pkt_pos[c] == 0);
						s_eop[c] <= eop;
						s_empty[c] <= eop ? r[3:0] : 4'd0;
						s_err[c] <= eop && (r[6:4] == 3'd0);
						s_valid[c] <= 1'b1;
						pkt_pos[c] = eop ? 0 : pkt_pos[c] + 1;
						issued[c]++;
					end else begin
						s_valid[c] <= 1'b0;
					end
				end
			end
		end
	end

	////////////////////////////////////////
	// scoreboard bookkeeping

	always @(posedge clk) begin
		prev_ready <= out_ready;
		prev_arst <= arst;
		prev_out <= out_all;
		if (!arst) begin
			if (mapped) begin
				beats_checked++;
				if (take_is1 && exp_q1.size() != 0) begin
					void'(exp_q1.pop_front());
				end else if (!take_is1 && exp_q0.size() != 0) begin
					void'(exp_q0.pop_front());
				end
				run_len <= (last_ch == take_is1) ? run_len + 1 : 1;
				last_ch <= take_is1;
			end
			if (!fair_check) begin
				run_len <= 0;
			end
			if (s_valid[0] && rdy[0]) begin
				accepted[0]++;
				exp_q0.push_back(expect_beat(s_data[0], s_sop[0], s_eop[0], s_empty[0], s_err[0]));
			end
			if (s_valid[1] && rdy[1]) begin
				accepted[1]++;
				exp_q1.push_back(expect_beat(s_data[1], s_sop[1], s_eop[1], s_empty[1], s_err[1]));
			end
			head0 <= (exp_q0.size() != 0) ? exp_q0[0] : '0;
			head1 <= (exp_q1.size() != 0) ? exp_q1[0] : '0;
			head_valid <= {exp_q1.size() != 0, exp_q0.size() != 0};
		end
	end

	////////////////////////////////////////
	// checks

	a_reset_quiet: assert property (@(posedge clk) (arst || prev_arst) |-> !out_valid && rdy == 2'b00)
		else report_fault("output valid or a channel ready was high in or just after reset");

	a_readback: assert property (@(posedge clk) disable iff (arst) rd_check |-> cfg_rdata == rd_expect)
		else report_mismatch("cfg_rdata", 144'($sampled(rd_expect)), 144'($sampled(cfg_rdata)));

	a_chan_known: assert property (@(posedge clk) disable iff (arst) take |-> take_is0 || take_is1)
		else begin
			$display("Mismatch at %0t ns: out_chan expected %0h or %0h actual %0h", $time,
				$sampled(id_model[0]), $sampled(id_model[1]), $sampled(out_chan));
			errors++;
		end

	a_no_extra: assert property (@(posedge clk) disable iff (arst) mapped |-> exp_avail)
		else report_fault("a beat came out on a channel with no beat outstanding");

	a_data: assert property (@(posedge clk) disable iff (arst) mapped && exp_avail |->
		out_data == exp_data)
		else report_mismatch("out_data", 144'($sampled(exp_data)), 144'($sampled(out_data)));

	a_num: assert property (@(posedge clk) disable iff (arst) mapped && exp_avail |->
		out_num_valid == exp_num)
		else report_mismatch("out_num_valid", 144'($sampled(exp_num)),
			144'($sampled(out_num_valid)));

	a_eop: assert property (@(posedge clk) disable iff (arst) mapped && exp_avail |->
		out_eopbits == exp_code)
		else report_mismatch("out_eopbits", 144'($sampled(exp_code)), 144'($sampled(out_eopbits)));

	a_sop: assert property (@(posedge clk) disable iff (arst) mapped && exp_avail |->
		out_sop == exp_sop)
		else report_mismatch("out_sop", 144'($sampled(exp_sop)), 144'($sampled(out_sop)));

	// a third beat in a row for one channel while the other waits breaks the rotation
	a_fair: assert property (@(posedge clk) disable iff (arst)
		fair_check && mapped && (take_is1 ? s_valid[0] : s_valid[1]) |->
		!(run_len >= 2 && last_ch == take_is1))
		else report_fault("one channel got a third beat in a row while the other waited");

	a_bp_ready: assert property (@(posedge clk) disable iff (arst) !out_ready |-> rdy == 2'b00)
		else report_mismatch("channel readies", 144'(0), 144'($sampled(rdy)));

	a_bp_hold: assert property (@(posedge clk) disable iff (arst) !prev_ready |-> out_all == prev_out)
		else report_mismatch("output stream", 144'($sampled(prev_out)), 144'($sampled(out_all)));

	a_dis_ready: assert property (@(posedge clk) disable iff (arst) (rdy & dis_check) == 2'b00)
		else report_fault("a disabled channel saw ready high");

	a_dis_chan: assert property (@(posedge clk) disable iff (arst)
		take |-> !(dis_check[0] && take_is0) && !(dis_check[1] && take_is1))
		else report_fault("a beat came out tagged with a disabled channel number");

	////////////////////////////////////////
	// test sequence

	initial begin : watchdog
		cycles = 0;
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", cycle_limit);
		$display("Regression failed");
		$finish;
	end

	initial begin : main_seq
		arst = 1'b1;
		cfg_wr = 1'b0;
		cfg_addr = '0;
		cfg_wdata = '0;
		s_data[0] = '0;
		s_data[1] = '0;
		s_empty[0] = '0;
		s_empty[1] = '0;
		s_sop = '0;
		s_eop = '0;
		s_valid = '0;
		s_err = '0;
		out_ready = 1'b1;
		lcg_state = 32'd42565;
		target[0] = 0;
		target[1] = 0;
		issued[0] = 0;
		issued[1] = 0;
		accepted[0] = 0;
		accepted[1] = 0;
		pkt_pos[0] = 0;
		pkt_pos[1] = 0;
		pkt_len[0] = 1;
		pkt_len[1] = 1;
		errors = 0;
		beats_checked = 0;
		tests_run = 0;
		run_len = 0;
		last_ch = 1'b0;
		gap_mode = 1'b0;
		bp_mode = 1'b0;
		fair_check = 1'b0;
		dis_check = 2'b00;
		id_model[0] = chan_id0_rst;
		id_model[1] = chan_id1_rst;
		rd_check = 1'b0;
		rd_expect = '0;
		prev_ready = 1'b1;
		prev_arst = 1'b1;
		prev_out = '0;
		head0 = '0;
		head1 = '0;
		head_valid = 2'b00;
		repeat (4) @(posedge clk);
		arst <= 1'b0;
		@(posedge clk);

		// reset values, then each address written and read back
		cfg_check(cfg_addr_enables, 8'h00);
		cfg_check(cfg_addr_chan0, 8'h00);
		cfg_check(cfg_addr_chan1, 8'h01);
		cfg_write(cfg_addr_enables, 8'hfd);
		cfg_check(cfg_addr_enables, 8'h01);
		cfg_write(cfg_addr_chan0, 8'h5a);
		cfg_check(cfg_addr_chan0, 8'h5a);
		cfg_write(cfg_addr_chan1, 8'ha7);
		cfg_check(cfg_addr_chan1, 8'ha7);
		cfg_write(2'd3, 8'hff);
		cfg_check(2'd3, 8'h00);
		cfg_write(cfg_addr_enables, 8'h03);
		cfg_check(cfg_addr_enables, 8'h03);
		test_done("reset and configuration");

		gap_mode <= 1'b1;
		add_traffic(40, 40);
		wait_drained();
		test_done("beat conversion");

		gap_mode <= 1'b0;
		fair_check <= 1'b1;
		add_traffic(30, 30);
		wait_drained();
		fair_check <= 1'b0;
		test_done("order and fairness");

		// channel 1 off while channel 0 keeps flowing
		cfg_write(cfg_addr_enables, 8'h01);
		repeat (5) @(posedge clk);
		dis_check <= 2'b10;
		gap_mode <= 1'b1;
		add_traffic(30, 10);
		@(negedge clk);
		while (accepted[0] != target[0]) begin
			@(negedge clk);
		end
		@(posedge clk);
		dis_check <= 2'b00;
		cfg_write(cfg_addr_enables, 8'h03);
		wait_drained();
		test_done("enables");

		bp_mode <= 1'b1;
		add_traffic(40, 40);
		wait_drained();
		bp_mode <= 1'b0;
		test_done("back-pressure");

		cfg_write(cfg_addr_chan0, 8'h21);
		cfg_write(cfg_addr_chan1, 8'h37);
		add_traffic(20, 20);
		wait_drained();
		test_done("renumbering");

		assert (exp_q0.size() == 0 && exp_q1.size() == 0)
			else report_fault("beats were left in the scoreboard at the end of the run");
		$display("tests %0d, beats checked %0d, errors %0d", tests_run, beats_checked, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== files.f ====
rtl/ilk_tx_pkg.sv
rtl/avl_to_ilk_adapter.sv
rtl/rr_arbiter.sv
rtl/tx_chan_config.sv
rtl/tx_two_chan_arbiter.sv
rtl/ilk_tx_top.sv
bench/tb_ilk_tx.sv

// ==== rtl/avl_to_ilk_adapter.sv ====
// combinational adapter from one Avalon-ST beat to an Interlaken word count and eop code
`timescale 1ns/1ns

module avl_to_ilk_adapter (
	input logic [ilk_tx_pkg::dat_width-1:0] avl_data,
	input logic avl_sop,
	input logic avl_eop,
	input logic avl_valid,
	input logic [ilk_tx_pkg::empty_width-1:0] avl_empty,
	input logic avl_error,
	output logic avl_ready,

	output logic [ilk_tx_pkg::dat_width-1:0] ilk_data,
	output logic [ilk_tx_pkg::log_dat_words-1:0] ilk_num_valid,
	output logic ilk_sop,
	output logic [3:0] ilk_eopbits,
	output logic ilk_valid,
	input logic ilk_ready
);

	import ilk_tx_pkg::*;

	// empty bytes split into whole unused words and a partial word
	logic [empty_width-word_byte_bits-1:0] empty_words;
	logic [word_byte_bits-1:0] empty_bytes;
	logic [word_byte_bits-1:0] last_bytes;

	assign empty_words = avl_empty[empty_width-1:word_byte_bits];
	assign empty_bytes = avl_empty[word_byte_bits-1:0];

	// a full last word wraps to zero, which the code reads as eight bytes
	assign last_bytes = word_byte_bits'(word_bytes - empty_bytes);

	////////////////////////////////////////
	// word count

	always_comb begin
		if (avl_eop) begin
			ilk_num_valid = log_dat_words'(num_dat_words - empty_words);
		end else begin
			ilk_num_valid = log_dat_words'(num_dat_words);
		end
	end

	////////////////////////////////////////
	// end-of-packet code

	always_comb begin
		if (!avl_eop) begin
			ilk_eopbits = eop_none;
		end else if (avl_error) begin
			// an errored packet drops the byte count entirely
			ilk_eopbits = eop_error;
		end else begin
			ilk_eopbits = eop_flag | {1'b0, last_bytes};
		end
	end

	// payload and framing go straight through with no latency
	assign ilk_data = avl_data;
	assign ilk_sop = avl_sop;
	assign ilk_valid = avl_valid;

	// the downstream grant is the source's ready
	assign avl_ready = ilk_ready;

endmodule

// ==== rtl/ilk_tx_pkg.sv ====
// shared sizes, register addresses and end-of-packet codes for the Interlaken transmit front end
package ilk_tx_pkg;

	////////////////////////////////////////
	// beat geometry

	// number of 64-bit words carried by one beat
	localparam int num_dat_words = 2;
	// enough bits to hold 0 to num_dat_words inclusive
	localparam int log_dat_words = 2;
	localparam int dat_width = 64 * num_dat_words;

	// bytes in one 64-bit word and the bits to index them
	localparam int word_bytes = 8;
	localparam int word_byte_bits = 3;

	// Avalon empty field, counts unused bytes in the beat
	localparam int empty_width = 4;

	////////////////////////////////////////
	// end-of-packet codes

	localparam logic [3:0] eop_none = 4'b0000;
	localparam logic [3:0] eop_error = 4'b0001;
	// top bit marks a good end, low 3 bits give bytes in the last word (0 means 8)
	localparam logic [3:0] eop_flag = 4'b1000;

	////////////////////////////////////////
	// channels and configuration registers

	localparam int num_chans = 2;
	localparam int chan_width = 8;
	localparam int cfg_addr_width = 2;

	localparam logic [cfg_addr_width-1:0] cfg_addr_enables = 2'd0;
	localparam logic [cfg_addr_width-1:0] cfg_addr_chan0 = 2'd1;
	localparam logic [cfg_addr_width-1:0] cfg_addr_chan1 = 2'd2;

	// channel numbers seen after reset
	localparam logic [chan_width-1:0] chan_id0_rst = 8'd0;
	localparam logic [chan_width-1:0] chan_id1_rst = 8'd1;

endpackage

// ==== rtl/ilk_tx_top.sv ====
// top level of the two-channel transmit front end, configuration block beside the arbiter
`timescale 1ns/1ns

module ilk_tx_top (
	input logic clk,
	input logic arst,

	input logic cfg_wr,
	input logic [ilk_tx_pkg::cfg_addr_width-1:0] cfg_addr,
	input logic [ilk_tx_pkg::chan_width-1:0] cfg_wdata,
	output logic [ilk_tx_pkg::chan_width-1:0] cfg_rdata,

	input logic [ilk_tx_pkg::dat_width-1:0] ch0_avl_data,
	input logic ch0_avl_sop,
	input logic ch0_avl_eop,
	input logic ch0_avl_valid,
	input logic [ilk_tx_pkg::empty_width-1:0] ch0_avl_empty,
	input logic ch0_avl_error,
	output logic ch0_avl_ready,

	input logic [ilk_tx_pkg::dat_width-1:0] ch1_avl_data,
	input logic ch1_avl_sop,
	input logic ch1_avl_eop,
	input logic ch1_avl_valid,
	input logic [ilk_tx_pkg::empty_width-1:0] ch1_avl_empty,
	input logic ch1_avl_error,
	output logic ch1_avl_ready,

	output logic [ilk_tx_pkg::log_dat_words-1:0] out_num_valid,
	output logic [ilk_tx_pkg::dat_width-1:0] out_data,
	output logic [ilk_tx_pkg::chan_width-1:0] out_chan,
	output logic out_sop,
	output logic [3:0] out_eopbits,
	input logic out_ready,
	output logic out_valid
);

	import ilk_tx_pkg::*;

	// configuration levels into the arbiter
	logic [num_chans-1:0] chan_enables;
	logic [chan_width-1:0] chan_id0;
	logic [chan_width-1:0] chan_id1;

	tx_chan_config u_cfg (
		.clk(clk),
		.arst(arst),
		.cfg_wr(cfg_wr),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.cfg_rdata(cfg_rdata),
		.chan_enables(chan_enables),
		.chan_id0(chan_id0),
		.chan_id1(chan_id1)
	);

	tx_two_chan_arbiter u_arb (
		.clk(clk),
		.arst(arst),
		.chan_enables(chan_enables),
		.chan_id0(chan_id0),
		.chan_id1(chan_id1),
		.ch0_avl_data(ch0_avl_data),
		.ch0_avl_sop(ch0_avl_sop),
		.ch0_avl_eop(ch0_avl_eop),
		.ch0_avl_valid(ch0_avl_valid),
		.ch0_avl_empty(ch0_avl_empty),
		.ch0_avl_error(ch0_avl_error),
		.ch0_avl_ready(ch0_avl_ready),
		.ch1_avl_data(ch1_avl_data),
		.ch1_avl_sop(ch1_avl_sop),
		.ch1_avl_eop(ch1_avl_eop),
		.ch1_avl_valid(ch1_avl_valid),
		.ch1_avl_empty(ch1_avl_empty),
		.ch1_avl_error(ch1_avl_error),
		.ch1_avl_ready(ch1_avl_ready),
		.out_num_valid(out_num_valid),
		.out_data(out_data),
		.out_chan(out_chan),
		.out_sop(out_sop),
		.out_eopbits(out_eopbits),
		.out_ready(out_ready),
		.out_valid(out_valid)
	);

endmodule

// ==== rtl/rr_arbiter.sv ====
// combinational rotating-base priority arbiter, one-hot or zero grant of any width
`timescale 1ns/1ns

module rr_arbiter #(
	parameter int WIDTH = 2
) (
	input logic [WIDTH-1:0] req,
	input logic [WIDTH-1:0] base,
	output logic [WIDTH-1:0] grant
);

	// requests repeated twice so the search can wrap past the top bit
	logic [2*WIDTH-1:0] dbl_req;
	logic [2*WIDTH-1:0] dbl_base;
	logic [2*WIDTH-1:0] dbl_grant;

	assign dbl_req = {req, req};
	assign dbl_base = {{WIDTH{1'b0}}, base};

	// subtracting the one-hot base clears the lowest request at or above it,
	// so the surviving difference bit marks the winner
	assign dbl_grant = dbl_req & ~(dbl_req - dbl_base);

	// the winner is in one half or the other, never both
	assign grant = dbl_grant[WIDTH-1:0] | dbl_grant[2*WIDTH-1:WIDTH];

endmodule

// ==== rtl/tx_chan_config.sv ====
// software register block holding channel enables and channel numbers, with readback
`timescale 1ns/1ns

module tx_chan_config (
	input logic clk,
	input logic arst,

	input logic cfg_wr,
	input logic [ilk_tx_pkg::cfg_addr_width-1:0] cfg_addr,
	input logic [ilk_tx_pkg::chan_width-1:0] cfg_wdata,
	output logic [ilk_tx_pkg::chan_width-1:0] cfg_rdata,

	output logic [ilk_tx_pkg::num_chans-1:0] chan_enables,
	output logic [ilk_tx_pkg::chan_width-1:0] chan_id0,
	output logic [ilk_tx_pkg::chan_width-1:0] chan_id1
);

	import ilk_tx_pkg::*;

	////////////////////////////////////////
	// register writes

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			chan_enables <= '0;
			chan_id0 <= chan_id0_rst;
			chan_id1 <= chan_id1_rst;
		end else if (cfg_wr) begin
			case (cfg_addr)
				cfg_addr_enables: begin
					chan_enables <= cfg_wdata[num_chans-1:0];
				end
				cfg_addr_chan0: begin
					chan_id0 <= cfg_wdata;
				end
				cfg_addr_chan1: begin
					chan_id1 <= cfg_wdata;
				end
				default: begin
					// writes to the spare address are dropped
				end
			endcase
		end
	end

	////////////////////////////////////////
	// readback

	// combinational from the address, unused bits read as zero
	always_comb begin
		cfg_rdata = '0;
		case (cfg_addr)
			cfg_addr_enables: begin
				cfg_rdata[num_chans-1:0] = chan_enables;
			end
			cfg_addr_chan0: begin
				cfg_rdata = chan_id0;
			end
			cfg_addr_chan1: begin
				cfg_rdata = chan_id1;
			end
			default: begin
				cfg_rdata = '0;
			end
		endcase
	end

endmodule

// ==== rtl/tx_two_chan_arbiter.sv ====
// two-channel per-beat arbiter that merges adapted Avalon-ST beats onto one tagged stream
`timescale 1ns/1ns

module tx_two_chan_arbiter (
	input logic clk,
	input logic arst,

	input logic [ilk_tx_pkg::num_chans-1:0] chan_enables,
	input logic [ilk_tx_pkg::chan_width-1:0] chan_id0,
	input logic [ilk_tx_pkg::chan_width-1:0] chan_id1,

	input logic [ilk_tx_pkg::dat_width-1:0] ch0_avl_data,
	input logic ch0_avl_sop,
	input logic ch0_avl_eop,
	input logic ch0_avl_valid,
	input logic [ilk_tx_pkg::empty_width-1:0] ch0_avl_empty,
	input logic ch0_avl_error,
	output logic ch0_avl_ready,

	input logic [ilk_tx_pkg::dat_width-1:0] ch1_avl_data,
	input logic ch1_avl_sop,
	input logic ch1_avl_eop,
	input logic ch1_avl_valid,
	input logic [ilk_tx_pkg::empty_width-1:0] ch1_avl_empty,
	input logic ch1_avl_error,
	output logic ch1_avl_ready,

	output logic [ilk_tx_pkg::log_dat_words-1:0] out_num_valid,
	output logic [ilk_tx_pkg::dat_width-1:0] out_data,
	output logic [ilk_tx_pkg::chan_width-1:0] out_chan,
	output logic out_sop,
	output logic [3:0] out_eopbits,
	input logic out_ready,
	output logic out_valid
);

	import ilk_tx_pkg::*;

	// adapted beats, one set per channel
	logic [dat_width-1:0] ch0_data;
	logic [log_dat_words-1:0] ch0_num_valid;
	logic ch0_sop;
	logic [3:0] ch0_eopbits;
	logic ch0_valid;
	logic ch0_ready;

	logic [dat_width-1:0] ch1_data;
	logic [log_dat_words-1:0] ch1_num_valid;
	logic ch1_sop;
	logic [3:0] ch1_eopbits;
	logic ch1_valid;
	logic ch1_ready;

	logic [num_chans-1:0] req;
	logic [num_chans-1:0] base;
	logic [num_chans-1:0] grant;
	logic [num_chans-1:0] grant_next;
	logic enc_grant;

	avl_to_ilk_adapter u_adapt0 (
		.avl_data(ch0_avl_data),
		.avl_sop(ch0_avl_sop),
		.avl_eop(ch0_avl_eop),
		.avl_valid(ch0_avl_valid),
		.avl_empty(ch0_avl_empty),
		.avl_error(ch0_avl_error),
		.avl_ready(ch0_avl_ready),
		.ilk_data(ch0_data),
		.ilk_num_valid(ch0_num_valid),
		.ilk_sop(ch0_sop),
		.ilk_eopbits(ch0_eopbits),
		.ilk_valid(ch0_valid),
		.ilk_ready(ch0_ready)
	);

	avl_to_ilk_adapter u_adapt1 (
		.avl_data(ch1_avl_data),
		.avl_sop(ch1_avl_sop),
		.avl_eop(ch1_avl_eop),
		.avl_valid(ch1_avl_valid),
		.avl_empty(ch1_avl_empty),
		.avl_error(ch1_avl_error),
		.avl_ready(ch1_avl_ready),
		.ilk_data(ch1_data),
		.ilk_num_valid(ch1_num_valid),
		.ilk_sop(ch1_sop),
		.ilk_eopbits(ch1_eopbits),
		.ilk_valid(ch1_valid),
		.ilk_ready(ch1_ready)
	);

	////////////////////////////////////////
	// request qualification and arbitration

	// a request needs the enable, a valid beat and at least one word in it
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			req <= '0;
			base <= num_chans'(1);
			grant <= '0;
			enc_grant <= 1'b0;
		end else if (out_ready) begin
			req[0] <= chan_enables[0] & ch0_valid & (|ch0_num_valid);
			req[1] <= chan_enables[1] & ch1_valid & (|ch1_num_valid);
			base <= {base[num_chans-2:0], base[num_chans-1]};
			grant <= grant_next;
			enc_grant <= grant_next[1];
		end
	end

	rr_arbiter #(
		.WIDTH(num_chans)
	) u_arb (
		.req(req),
		.base(base),
		.grant(grant_next)
	);

	////////////////////////////////////////
	// output registers

	// a stale grant or a dropped valid turns the slot into a bubble
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			out_num_valid <= '0;
		end else if (out_ready) begin
			if (!(|grant)) begin
				out_num_valid <= '0;
			end else if (!enc_grant) begin
				out_num_valid <= ch0_num_valid & {log_dat_words{ch0_valid}};
			end else begin
				out_num_valid <= ch1_num_valid & {log_dat_words{ch1_valid}};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (out_ready) begin
			if (!enc_grant) begin
				out_data <= ch0_data;
				out_sop <= ch0_sop;
				out_eopbits <= ch0_eopbits;
				out_chan <= chan_id0;
			end else begin
				out_data <= ch1_data;
				out_sop <= ch1_sop;
				out_eopbits <= ch1_eopbits;
				out_chan <= chan_id1;
			end
		end
	end

	// the granted source is taken on the same edge the output loads its beat
	assign ch0_ready = grant[0] & out_ready;
	assign ch1_ready = grant[1] & out_ready;
	assign out_valid = |out_num_valid;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the transmit front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_ilk_tx -f files.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "compile step failed with status $status"
	exit 1
fi

output=$(./obj_dir/Vtb_ilk_tx)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Regression passed"; then
	exit 0
fi
echo "pass message not found in the simulation output"
exit 1
